//--- hw/fifo.sv
`timescale 1ns/10ps

module fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 8
) (
    input  logic             clk_i,
    input  logic             reset_i,
    input  logic             wr_i,
    input  logic             rd_i,
    input  logic [WIDTH-1:0] data_in_i,
    output logic [WIDTH-1:0] data_out_o,
    output logic             empty_o,
    output logic             full_o
);

    // pointer width, at least one bit
    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [WIDTH-1:0] mem [DEPTH];
    logic [AW-1:0]    wr_ptr_q;
    logic [AW-1:0]    rd_ptr_q;
    logic [AW:0]      count_q;
    logic             push;
    logic             pop;

    // strobes that really move data
    assign push = wr_i && !full_o;
    assign pop  = rd_i && !empty_o;

    // flags straight from the count
    assign empty_o = (count_q == '0);
    assign full_o  = (count_q == (AW+1)'(DEPTH));

    // head entry, no read latency
    assign data_out_o = mem[rd_ptr_q];

    // occupancy and pointers
    always_ff @(posedge clk_i) begin
        if (!reset_i) begin
            count_q  <= '0;
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            // push and pop together leave the count alone
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
            if (push) begin
                // wrap by compare, depth need not be a power of two
                wr_ptr_q <= (wr_ptr_q == AW'(DEPTH-1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == AW'(DEPTH-1)) ? '0 : rd_ptr_q + 1'b1;
            end
        end
    end

    // storage
    always_ff @(posedge clk_i) begin
        if (push) begin
            mem[wr_ptr_q] <= data_in_i;
        end
    end

    // write into a full fifo is refused, nothing moves
    a_no_push_full: assert property (@(posedge clk_i) disable iff (!reset_i)
        (full_o && wr_i && !rd_i) |=> (full_o && $stable(wr_ptr_q)));

    // read from an empty fifo is refused, head stays put
    a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!reset_i)
        (empty_o && rd_i && !wr_i) |=> (empty_o && $stable(rd_ptr_q)));

endmodule

//--- hw/uart_pkg.sv
`include "uart_settings.svh"

package uart_pkg;

    // one serial data byte
    typedef logic [7:0] byte_t;

    // clock cycles per serial bit
    typedef logic [15:0] divisor_t;

    // register word address on the bus
    typedef logic [1:0] wb_addr_t;

    // wishbone data word
    typedef logic [31:0] wb_data_t;

    // fifo occupancy, one bit wider than the address
    // so that a full fifo can hold DEPTH
    typedef logic [`UART_FIFO_AW:0] fifo_cnt_t;

endpackage

//--- hw/uart_rx.sv
`timescale 1ns/10ps

module uart_rx (
    input  logic               clk_i,
    input  logic               reset_i,
    input  uart_pkg::divisor_t divisor_i,
    input  logic               rx_i,
    output logic               rx_valid_o,
    output uart_pkg::byte_t    rx_byte_o
);

    typedef enum logic [1:0] {IDLE, START, DATA, STOP} state_t;

    state_t             state_q;
    uart_pkg::divisor_t div_q;
    uart_pkg::divisor_t mid_q;
    uart_pkg::divisor_t cnt_q;
    uart_pkg::byte_t    shift_q;
    logic [2:0]         bit_q;
    logic               rx_meta_q;
    logic               rx_sync_q;
    logic               rx_prev_q;
    logic               bit_end;

    // full bit period elapsed
    assign bit_end = (cnt_q == div_q - 16'd1);

    // assembled byte, stable while valid pulses
    assign rx_byte_o = shift_q;

    // two flop synchronizer, plus one for edge detect
    always_ff @(posedge clk_i) begin
        if (!reset_i) begin
            rx_meta_q <= 1'b1;
            rx_sync_q <= 1'b1;
            rx_prev_q <= 1'b1;
        end else begin
            rx_meta_q <= rx_i;
            rx_sync_q <= rx_meta_q;
            rx_prev_q <= rx_sync_q;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_i) begin
            state_q    <= IDLE;
            div_q      <= '0;
            mid_q      <= '0;
            cnt_q      <= '0;
            bit_q      <= '0;
            rx_valid_o <= 1'b0;
        end else begin
            rx_valid_o <= 1'b0;
            case (state_q)
                IDLE: begin
                    // falling edge opens a possible start bit
                    if (rx_prev_q && !rx_sync_q) begin
                        div_q   <= divisor_i;
                        mid_q   <= divisor_i >> 1;
                        cnt_q   <= '0;
                        state_q <= START;
                    end
                end
                START: begin
                    if (cnt_q == mid_q) begin
                        // still low at mid-bit, else a glitch
                        cnt_q   <= '0;
                        bit_q   <= '0;
                        state_q <= rx_sync_q ? IDLE : DATA;
                    end else begin
                        cnt_q <= cnt_q + 16'd1;
                    end
                end
                DATA: begin
                    if (bit_end) begin
                        cnt_q <= '0;
                        bit_q <= bit_q + 3'd1;
                        if (bit_q == 3'd7) begin
                            state_q <= STOP;
                        end
                    end else begin
                        cnt_q <= cnt_q + 16'd1;
                    end
                end
                default: begin
                    if (bit_end) begin
                        // bad stop bit, frame silently lost
                        rx_valid_o <= rx_sync_q;
                        state_q    <= IDLE;
                    end else begin
                        cnt_q <= cnt_q + 16'd1;
                    end
                end
            endcase
        end
    end

    // lsb arrives first, shift in from the top
    always_ff @(posedge clk_i) begin
        if (state_q == DATA && bit_end) begin
            shift_q <= {rx_sync_q, shift_q[7:1]};
        end
    end

    // one push per frame
    a_valid_pulse: assert property (@(posedge clk_i) disable iff (!reset_i)
        rx_valid_o |=> !rx_valid_o);

endmodule

//--- hw/uart_settings.svh
`ifndef UART_SETTINGS_SVH
`define UART_SETTINGS_SVH

// fifo geometry, same for tx and rx
`define UART_FIFO_DEPTH 8
`define UART_FIFO_AW 3

// register word addresses
`define UART_REG_DATA 0
`define UART_REG_STATUS 1
`define UART_REG_DIV 2

// clocks per serial bit out of reset
`define UART_DIV_RESET 16

// status register bit positions
`define UART_ST_RX_EMPTY 0
`define UART_ST_RX_FULL 1
`define UART_ST_TX_EMPTY 2
`define UART_ST_TX_FULL 3
`define UART_ST_TX_DROP 4
`define UART_ST_RX_DROP 5

`endif

//--- hw/uart_top.sv
`timescale 1ns/10ps
`include "uart_settings.svh"

module uart_top (
    input  logic               clk_i,
    input  logic               reset_i,
    input  logic               wb_cyc_i,
    input  logic               wb_stb_i,
    input  logic               wb_we_i,
    input  uart_pkg::wb_addr_t wb_adr_i,
    input  uart_pkg::wb_data_t wb_dat_i,
    output uart_pkg::wb_data_t wb_dat_o,
    output logic               wb_ack_o,
    input  logic               rx_i,
    output logic               tx_o
);

    // tx path
    logic               tx_wr;
    logic               tx_pop;
    logic               tx_fifo_empty;
    logic               tx_fifo_full;
    uart_pkg::byte_t    tx_wr_data;
    uart_pkg::byte_t    tx_head;

    // rx path
    logic               rx_rd;
    logic               rx_push;
    logic               rx_valid;
    logic               rx_fifo_empty;
    logic               rx_fifo_full;
    uart_pkg::byte_t    rx_byte;
    uart_pkg::byte_t    rx_push_data;
    uart_pkg::byte_t    rx_head;

    // shared bit timing
    uart_pkg::divisor_t divisor;

    wb_regs u_wb_regs (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .wb_cyc_i       (wb_cyc_i),
        .wb_stb_i       (wb_stb_i),
        .wb_we_i        (wb_we_i),
        .wb_adr_i       (wb_adr_i),
        .wb_dat_i       (wb_dat_i),
        .wb_dat_o       (wb_dat_o),
        .wb_ack_o       (wb_ack_o),
        .tx_wr_o        (tx_wr),
        .tx_data_o      (tx_wr_data),
        .tx_full_i      (tx_fifo_full),
        .tx_empty_i     (tx_fifo_empty),
        .rx_rd_o        (rx_rd),
        .rx_data_i      (rx_head),
        .rx_full_i      (rx_fifo_full),
        .rx_empty_i     (rx_fifo_empty),
        .rx_valid_i     (rx_valid),
        .rx_byte_i      (rx_byte),
        .rx_push_o      (rx_push),
        .rx_push_data_o (rx_push_data),
        .divisor_o      (divisor)
    );

    // host to line
    fifo #(.WIDTH($bits(uart_pkg::byte_t)), .DEPTH(`UART_FIFO_DEPTH)) tx_fifo (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .wr_i       (tx_wr),
        .rd_i       (tx_pop),
        .data_in_i  (tx_wr_data),
        .data_out_o (tx_head),
        .empty_o    (tx_fifo_empty),
        .full_o     (tx_fifo_full)
    );

    // line to host
    fifo #(.WIDTH($bits(uart_pkg::byte_t)), .DEPTH(`UART_FIFO_DEPTH)) rx_fifo (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .wr_i       (rx_push),
        .rd_i       (rx_rd),
        .data_in_i  (rx_push_data),
        .data_out_o (rx_head),
        .empty_o    (rx_fifo_empty),
        .full_o     (rx_fifo_full)
    );

    uart_tx u_uart_tx (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .divisor_i    (divisor),
        .fifo_empty_i (tx_fifo_empty),
        .fifo_data_i  (tx_head),
        .fifo_pop_o   (tx_pop),
        .tx_o         (tx_o)
    );

    uart_rx u_uart_rx (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .divisor_i  (divisor),
        .rx_i       (rx_i),
        .rx_valid_o (rx_valid),
        .rx_byte_o  (rx_byte)
    );

endmodule

//--- hw/uart_tx.sv
`timescale 1ns/10ps

module uart_tx (
    input  logic               clk_i,
    input  logic               reset_i,
    input  uart_pkg::divisor_t divisor_i,
    input  logic               fifo_empty_i,
    input  uart_pkg::byte_t    fifo_data_i,
    output logic               fifo_pop_o,
    output logic               tx_o
);

    typedef enum logic [1:0] {IDLE, START, DATA, STOP} state_t;

    state_t             state_q;
    uart_pkg::divisor_t div_q;
    uart_pkg::divisor_t cnt_q;
    uart_pkg::byte_t    shift_q;
    logic [2:0]         bit_q;
    logic               bit_end;

    // last cycle of the current bit period
    assign bit_end = (cnt_q == div_q - 16'd1);

    // take the head byte as soon as we are free
    assign fifo_pop_o = (state_q == IDLE) && !fifo_empty_i;

    always_ff @(posedge clk_i) begin
        if (!reset_i) begin
            state_q <= IDLE;
            div_q   <= '0;
            cnt_q   <= '0;
            bit_q   <= '0;
            tx_o    <= 1'b1;
        end else begin
            // bit period counter, held at zero when idle
            cnt_q <= (state_q == IDLE || bit_end) ? '0 : cnt_q + 16'd1;
            case (state_q)
                IDLE: begin
                    if (fifo_pop_o) begin
                        // divisor frozen for the whole frame
                        div_q   <= divisor_i;
                        bit_q   <= '0;
                        tx_o    <= 1'b0;
                        state_q <= START;
                    end
                end
                START: begin
                    if (bit_end) begin
                        tx_o    <= shift_q[0];
                        state_q <= DATA;
                    end
                end
                DATA: begin
                    if (bit_end) begin
                        if (bit_q == 3'd7) begin
                            // stop bit
                            tx_o    <= 1'b1;
                            state_q <= STOP;
                        end else begin
                            tx_o  <= shift_q[0];
                            bit_q <= bit_q + 3'd1;
                        end
                    end
                end
                default: begin
                    if (bit_end) begin
                        state_q <= IDLE;
                    end
                end
            endcase
        end
    end

    // data byte, lsb first, shifted at each bit boundary
    always_ff @(posedge clk_i) begin
        if (fifo_pop_o) begin
            shift_q <= fifo_data_i;
        end else if (bit_end && (state_q == START || state_q == DATA)) begin
            shift_q <= shift_q >> 1;
        end
    end

    // line sits at mark level between frames
    a_idle_high: assert property (@(posedge clk_i) disable iff (!reset_i)
        (state_q == IDLE) |-> tx_o);

endmodule

//--- hw/wb_regs.sv
`timescale 1ns/10ps
`include "uart_settings.svh"

module wb_regs (
    input  logic               clk_i,
    input  logic               reset_i,
    input  logic               wb_cyc_i,
    input  logic               wb_stb_i,
    input  logic               wb_we_i,
    input  uart_pkg::wb_addr_t wb_adr_i,
    input  uart_pkg::wb_data_t wb_dat_i,
    output uart_pkg::wb_data_t wb_dat_o,
    output logic               wb_ack_o,
    output logic               tx_wr_o,
    output uart_pkg::byte_t    tx_data_o,
    input  logic               tx_full_i,
    input  logic               tx_empty_i,
    output logic               rx_rd_o,
    input  uart_pkg::byte_t    rx_data_i,
    input  logic               rx_full_i,
    input  logic               rx_empty_i,
    input  logic               rx_valid_i,
    input  uart_pkg::byte_t    rx_byte_i,
    output logic               rx_push_o,
    output uart_pkg::byte_t    rx_push_data_o,
    output uart_pkg::divisor_t divisor_o
);

    logic               req;
    logic               wr_req;
    logic               rd_req;
    logic               tx_drop_q;
    logic               rx_drop_q;
    uart_pkg::wb_data_t status;
    uart_pkg::wb_data_t rd_data;

    // first cycle of a request only, the ack cycle is not a new one
    assign req    = wb_cyc_i && wb_stb_i && !wb_ack_o;
    assign wr_req = req && wb_we_i;
    assign rd_req = req && !wb_we_i;

    // tx fifo push, the fifo refuses it when full
    assign tx_wr_o   = wr_req && (wb_adr_i == `UART_REG_DATA);
    assign tx_data_o = wb_dat_i[7:0];

    // rx fifo pop on a data read, ignored by an empty fifo
    assign rx_rd_o = rd_req && (wb_adr_i == `UART_REG_DATA);

    // received bytes go straight into the rx fifo
    assign rx_push_o      = rx_valid_i;
    assign rx_push_data_o = rx_byte_i;

    // status word
    always_comb begin
        status                    = '0;
        status[`UART_ST_RX_EMPTY] = rx_empty_i;
        status[`UART_ST_RX_FULL]  = rx_full_i;
        status[`UART_ST_TX_EMPTY] = tx_empty_i;
        status[`UART_ST_TX_FULL]  = tx_full_i;
        status[`UART_ST_TX_DROP]  = tx_drop_q;
        status[`UART_ST_RX_DROP]  = rx_drop_q;
    end

    // read mux
    always_comb begin
        case (wb_adr_i)
            `UART_REG_DATA:   rd_data = rx_empty_i ? '0 : uart_pkg::wb_data_t'(rx_data_i);
            `UART_REG_STATUS: rd_data = status;
            `UART_REG_DIV:    rd_data = uart_pkg::wb_data_t'(divisor_o);
            default:          rd_data = '0;
        endcase
    end

    // ack, divisor and sticky drop flags
    always_ff @(posedge clk_i) begin
        if (!reset_i) begin
            wb_ack_o  <= 1'b0;
            divisor_o <= uart_pkg::divisor_t'(`UART_DIV_RESET);
            tx_drop_q <= 1'b0;
            rx_drop_q <= 1'b0;
        end else begin
            wb_ack_o <= req;
            if (wr_req && (wb_adr_i == `UART_REG_DIV)) begin
                divisor_o <= wb_dat_i[15:0];
            end
            // a new drop wins over the clear of a status read
            if (tx_wr_o && tx_full_i) begin
                tx_drop_q <= 1'b1;
            end else if (rd_req && (wb_adr_i == `UART_REG_STATUS)) begin
                tx_drop_q <= 1'b0;
            end
            if (rx_valid_i && rx_full_i) begin
                rx_drop_q <= 1'b1;
            end else if (rd_req && (wb_adr_i == `UART_REG_STATUS)) begin
                rx_drop_q <= 1'b0;
            end
        end
    end

    // read data registered alongside ack
    always_ff @(posedge clk_i) begin
        if (rd_req) begin
            wb_dat_o <= rd_data;
        end
    end

    // single cycle ack per request
    a_ack_once: assert property (@(posedge clk_i) disable iff (!reset_i)
        wb_ack_o |=> !wb_ack_o);

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the uart testbench with verilator, from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module uart_tb -f src.f -o uart_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/uart_sim > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "Something failed" sim.log; then
    exit 1
fi
exit 0

//--- src.f
+incdir+hw
hw/uart_pkg.sv
hw/fifo.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/wb_regs.sv
hw/uart_top.sv
test/uart_tb.sv

//--- test/uart_tb.sv
`timescale 1ns/10ps
`include "uart_settings.svh"

module uart_tb;

    // run budget from the bytes on the line and the slowest divisor
    localparam int TOTAL_BYTES = 30;
    localparam int MAX_DIV     = 7;
    localparam int CYCLE_LIMIT = TOTAL_BYTES * 10 * MAX_DIV + 2000;

    logic               clk_i;
    logic               reset_i;
    logic               wb_cyc_i;
    logic               wb_stb_i;
    logic               wb_we_i;
    uart_pkg::wb_addr_t wb_adr_i;
    uart_pkg::wb_data_t wb_dat_i;
    uart_pkg::wb_data_t wb_dat_o;
    logic               wb_ack_o;
    logic               tx_line;
    logic               rx_line;
    logic               block_loop;

    uart_pkg::byte_t    model_q[$];
    uart_pkg::byte_t    written[11];
    uart_pkg::byte_t    exp_byte;
    uart_pkg::wb_data_t rd;
    uart_pkg::wb_data_t exp_word;
    integer             seed;
    int                 errors;
    int                 checks;
    int                 cycle_cnt;
    int                 cur_div;
    int                 frame_left;
    int                 widx;
    int                 first;
    int                 got;
    int                 i;
    string              test_name;

    // serial loopback forced to mark level while blocked
    assign rx_line = block_loop ? 1'b1 : tx_line;

    uart_top uut (
        .clk_i    (clk_i),
        .reset_i  (reset_i),
        .wb_cyc_i (wb_cyc_i),
        .wb_stb_i (wb_stb_i),
        .wb_we_i  (wb_we_i),
        .wb_adr_i (wb_adr_i),
        .wb_dat_i (wb_dat_i),
        .wb_dat_o (wb_dat_o),
        .wb_ack_o (wb_ack_o),
        .rx_i     (rx_line),
        .tx_o     (tx_line)
    );

    // 100 ns clock
    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    // watchdog
    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Something failed");
            $finish;
        end
    end

    // follows 8N1 frames on tx and counts down to the end of each frame
    always @(negedge clk_i) begin
        if (!reset_i) begin
            frame_left <= 0;
        end else if (frame_left != 0) begin
            frame_left <= frame_left - 1;
        end else if (!tx_line) begin
            frame_left <= 10 * cur_div - 1;
        end
    end

    function automatic uart_pkg::byte_t random_byte();
        logic [31:0] r;
        r = $random(seed);
        return r[7:0];
    endfunction

    task automatic check_value(input string what, input uart_pkg::wb_data_t exp,
                               input uart_pkg::wb_data_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERR %s/%s expected %h actual %h", test_name, what, exp, act);
        end
    endtask

    // request stays up until the ack shows at a falling edge
    task automatic wait_for_ack();
        @(negedge clk_i);
        while (!wb_ack_o) begin
            @(negedge clk_i);
        end
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
    endtask

    task automatic write_reg(input uart_pkg::wb_addr_t addr, input uart_pkg::wb_data_t data);
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = 1'b1;
        wb_adr_i = addr;
        wb_dat_i = data;
        wait_for_ack();
    endtask

    task automatic read_reg(input uart_pkg::wb_addr_t addr, output uart_pkg::wb_data_t data);
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = 1'b0;
        wb_adr_i = addr;
        wait_for_ack();
        data = wb_dat_o;
    endtask

    task automatic set_divisor(input int d);
        write_reg(`UART_REG_DIV, uart_pkg::wb_data_t'(d));
        cur_div = d;
    endtask

    // waits for room in the tx fifo and then queues the byte in the model too
    task automatic send_byte(input uart_pkg::byte_t b);
        uart_pkg::wb_data_t st;
        read_reg(`UART_REG_STATUS, st);
        while (st[`UART_ST_TX_FULL]) begin
            read_reg(`UART_REG_STATUS, st);
        end
        write_reg(`UART_REG_DATA, {24'h0, b});
        model_q.push_back(b);
    endtask

    // tx fifo empty and then enough bit periods for the last frame to land
    task automatic wait_tx_drained();
        uart_pkg::wb_data_t st;
        read_reg(`UART_REG_STATUS, st);
        while (!st[`UART_ST_TX_EMPTY]) begin
            read_reg(`UART_REG_STATUS, st);
        end
        repeat (12 * cur_div) @(negedge clk_i);
    endtask

    task automatic check_received(input int n);
        uart_pkg::wb_data_t d;
        uart_pkg::byte_t    exp;
        int                 k;
        for (k = 0; k < n; k++) begin
            read_reg(`UART_REG_DATA, d);
            exp = model_q.pop_front();
            check_value("rx byte", {24'h0, exp}, d);
        end
    endtask

    initial begin
        seed       = 32'h9290_3c4e;
        errors     = 0;
        checks     = 0;
        cycle_cnt  = 0;
        cur_div    = `UART_DIV_RESET;
        block_loop = 1'b1;
        reset_i    = 1'b0;
        wb_cyc_i   = 1'b0;
        wb_stb_i   = 1'b0;
        wb_we_i    = 1'b0;
        wb_adr_i   = '0;
        wb_dat_i   = '0;
        repeat (3) @(negedge clk_i);
        reset_i    = 1'b1;
        block_loop = 1'b0;

        // both fifos empty with nothing dropped and the reset divisor
        test_name = "reset";
        exp_word = '0;
        exp_word[`UART_ST_RX_EMPTY] = 1'b1;
        exp_word[`UART_ST_TX_EMPTY] = 1'b1;
        read_reg(`UART_REG_STATUS, rd);
        check_value("status", exp_word, rd);
        read_reg(`UART_REG_DIV, rd);
        check_value("divisor", 32'd16, rd);

        test_name = "loopback";
        set_divisor(4);
        for (i = 0; i < 6; i++) begin
            send_byte(random_byte());
        end
        wait_tx_drained();
        check_received(6);
        read_reg(`UART_REG_STATUS, rd);
        check_value("rx_empty", 32'h1, {31'h0, rd[`UART_ST_RX_EMPTY]});

        // eleven writes back to back while the line goes nowhere
        test_name = "tx_overflow";
        block_loop = 1'b1;
        for (i = 0; i < 11; i++) begin
            written[i] = random_byte();
            write_reg(`UART_REG_DATA, {24'h0, written[i]});
        end
        read_reg(`UART_REG_STATUS, rd);
        check_value("tx_drop set", 32'h1, {31'h0, rd[`UART_ST_TX_DROP]});
        read_reg(`UART_REG_STATUS, rd);
        check_value("tx_drop clear", 32'h0, {31'h0, rd[`UART_ST_TX_DROP]});
        // reopen only in a stop bit or between frames
        while (!(tx_line && frame_left < cur_div)) begin
            @(negedge clk_i);
        end
        block_loop = 1'b0;
        wait_tx_drained();
        // whatever arrives keeps the write order
        widx = 0;
        got  = 0;
        read_reg(`UART_REG_STATUS, rd);
        while (!rd[`UART_ST_RX_EMPTY]) begin
            read_reg(`UART_REG_DATA, rd);
            first    = widx;
            exp_byte = (first < 11) ? written[first] : 8'h00;
            while (widx < 11 && written[widx] != rd[7:0]) begin
                widx++;
            end
            checks++;
            if (widx == 11) begin
                errors++;
                $display("ERR %s/order expected %h actual %h", test_name, exp_byte, rd[7:0]);
            end else begin
                widx++;
            end
            got++;
            read_reg(`UART_REG_STATUS, rd);
        end
        if (got == 0) begin
            errors++;
            $display("tx_overflow: no byte came back after the loopback was reopened");
        end

        // ten frames into an eight entry rx fifo
        test_name = "rx_overflow";
        for (i = 0; i < 10; i++) begin
            send_byte(random_byte());
        end
        wait_tx_drained();
        exp_word = '0;
        exp_word[`UART_ST_RX_FULL]  = 1'b1;
        exp_word[`UART_ST_TX_EMPTY] = 1'b1;
        exp_word[`UART_ST_RX_DROP]  = 1'b1;
        read_reg(`UART_REG_STATUS, rd);
        check_value("status", exp_word, rd);
        check_received(8);
        // last two were dropped by the rx side
        model_q.delete();

        test_name = "divisor_change";
        read_reg(`UART_REG_DATA, rd);
        check_value("empty read", 32'h0, rd);
        set_divisor(7);
        read_reg(`UART_REG_DIV, rd);
        check_value("divisor", 32'd7, rd);
        for (i = 0; i < 3; i++) begin
            send_byte(random_byte());
        end
        wait_tx_drained();
        check_received(3);
        read_reg(`UART_REG_STATUS, rd);
        check_value("rx_empty", 32'h1, {31'h0, rd[`UART_ST_RX_EMPTY]});

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule
